/* Makefile */
.PHONY: all compile run clean

all: run

compile: obj_dir/Vexec_core_tb

obj_dir/Vexec_core_tb: exec_core.f src/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing --assert -j 0 --top-module exec_core_tb \
		-f exec_core.f --Mdir obj_dir

run: compile
	./obj_dir/Vexec_core_tb | tee sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

/* exec_core.f */
src/core_pkg.sv
src/alu_lane.sv
src/reg_file.sv
src/exec_core.sv
+incdir+verif
verif/exec_core_tb.sv

/* src/alu_lane.sv */
`timescale 1ns/1ps

module alu_lane (
  input  logic                clk,
  input  logic                rst,
  input  logic                issue_valid,
  input  core_pkg::inst_u     inst,
  output core_pkg::reg_addr_t rs_addr,
  output core_pkg::reg_addr_t rt_addr,
  input  core_pkg::data_t     rs_data,
  input  core_pkg::data_t     rt_data,
  input  core_pkg::wb_t       fwd0,
  input  core_pkg::wb_t       fwd1,
  output core_pkg::wb_t       fwd,
  output core_pkg::wb_t       retire
);

  import core_pkg::*;

  typedef struct packed {
    logic                    valid;
    logic [opcode_width-1:0] opcode;
    logic                    use_imm;
    reg_addr_t               rs;
    reg_addr_t               rt;
    reg_addr_t               dest;
    logic [imm_width-1:0]    imm;
    logic [shamt_width-1:0]  shamt;
  } dec_t;

  typedef struct packed {
    logic                    valid;
    logic [opcode_width-1:0] opcode;
    reg_addr_t               dest;
    logic [shamt_width-1:0]  shamt;
    data_t                   a;
    data_t                   b;
  } ex_t;

  dec_t  dec_d;
  dec_t  dec_q;
  ex_t   ex_d;
  ex_t   ex_q;
  wb_t   retire_q;
  data_t alu_res;
  logic  lt;
  logic  is_r;
  logic  is_i;

  // lane 1 over lane 0 over the register file
  function automatic data_t pick_operand(reg_addr_t src, data_t rf_data, wb_t f0, wb_t f1);
    data_t result;
    if (f1.valid && f1.dest == src) begin
      result = f1.data;
    end else if (f0.valid && f0.dest == src) begin
      result = f0.data;
    end else begin
      result = rf_data;
    end
    return result;
  endfunction

  ////////////////////////////////////////
  // decode captured at the issue edge
  ////////////////////////////////////////

  always_comb begin
    is_r = 1'b0;
    is_i = 1'b0;
    case (inst.r.opcode)
      op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sll, op_srl: is_r = 1'b1;
      op_addi, op_andi, op_ori, op_lui: is_i = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    dec_d        = '0;
    dec_d.opcode = inst.r.opcode;
    dec_d.rs     = inst.r.rs;
    if (is_r) begin
      dec_d.rt    = inst.r.rt;
      dec_d.dest  = inst.r.rd;
      dec_d.shamt = inst.r.shamt;
    end else begin
      // rt is the destination here so there is no second source
      dec_d.dest    = inst.i.rt;
      dec_d.imm     = inst.i.imm;
      dec_d.use_imm = 1'b1;
    end
    dec_d.valid = issue_valid && (is_r || is_i) && dec_d.dest != '0;
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      dec_q <= dec_d;
    end
    if (rst) begin
      dec_q.valid <= 1'b0;
    end else begin
      dec_q.valid <= dec_d.valid;
    end
  end

  ////////////////////////////////////////
  // operand fetch with forwarding
  ////////////////////////////////////////

  assign rs_addr = dec_q.rs;
  assign rt_addr = dec_q.rt;

  always_comb begin
    ex_d.valid  = dec_q.valid;
    ex_d.opcode = dec_q.opcode;
    ex_d.dest   = dec_q.dest;
    ex_d.shamt  = dec_q.shamt;
    ex_d.a      = pick_operand(dec_q.rs, rs_data, fwd0, fwd1);
    if (dec_q.use_imm) begin
      ex_d.b = {{(data_width - imm_width){1'b0}}, dec_q.imm};
    end else begin
      ex_d.b = pick_operand(dec_q.rt, rt_data, fwd0, fwd1);
    end
  end

  always_ff @(posedge clk) begin
    if (dec_q.valid) begin
      ex_q <= ex_d;
    end
    if (rst) begin
      ex_q.valid <= 1'b0;
    end else begin
      ex_q.valid <= ex_d.valid;
    end
  end

  ////////////////////////////////////////
  // execute and retire
  ////////////////////////////////////////

  assign lt = $signed(ex_q.a) < $signed(ex_q.b);

  always_comb begin
    case (ex_q.opcode)
      op_add, op_addi: alu_res = ex_q.a + ex_q.b;
      op_sub:          alu_res = ex_q.a - ex_q.b;
      op_and, op_andi: alu_res = ex_q.a & ex_q.b;
      op_or, op_ori:   alu_res = ex_q.a | ex_q.b;
      op_xor:          alu_res = ex_q.a ^ ex_q.b;
      op_slt:          alu_res = {{(data_width - 1){1'b0}}, lt};
      op_sll:          alu_res = ex_q.b << ex_q.shamt;
      op_srl:          alu_res = ex_q.b >> ex_q.shamt;
      op_lui:          alu_res = ex_q.b << imm_width;
      default:         alu_res = '0;
    endcase
  end

  assign fwd.valid = ex_q.valid;
  assign fwd.dest  = ex_q.dest;
  assign fwd.data  = alu_res;

  always_ff @(posedge clk) begin
    retire_q <= fwd;
    if (rst) begin
      retire_q.valid <= 1'b0;
    end
  end

  assign retire = retire_q;

  // decode, operand and execute stages sit between issue and retire
  assert property (@(posedge clk) disable iff (rst) retire.valid |-> $past(issue_valid, 3))
    else $error("alu_lane: retire without a valid issue three cycles earlier");

endmodule

/* src/core_pkg.sv */
package core_pkg;

  ////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////

  localparam int data_width     = 32;
  localparam int inst_width     = 32;
  localparam int num_regs       = 32;
  localparam int reg_addr_width = 5;
  localparam int imm_width      = 16;
  localparam int shamt_width    = 5;
  localparam int opcode_width   = 6;

  // two lanes with rs and rt each
  localparam int num_rd_ports   = 4;

  ////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////

  // r-type
  localparam logic [opcode_width-1:0] op_add  = 6'h01;
  localparam logic [opcode_width-1:0] op_sub  = 6'h02;
  localparam logic [opcode_width-1:0] op_and  = 6'h03;
  localparam logic [opcode_width-1:0] op_or   = 6'h04;
  localparam logic [opcode_width-1:0] op_xor  = 6'h05;
  localparam logic [opcode_width-1:0] op_slt  = 6'h06;
  localparam logic [opcode_width-1:0] op_sll  = 6'h07;
  localparam logic [opcode_width-1:0] op_srl  = 6'h08;

  // i-type with zero-extended immediate
  localparam logic [opcode_width-1:0] op_addi = 6'h09;
  localparam logic [opcode_width-1:0] op_andi = 6'h0a;
  localparam logic [opcode_width-1:0] op_ori  = 6'h0b;
  localparam logic [opcode_width-1:0] op_lui  = 6'h0c;

  // unlisted opcodes decode as nop

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef logic [reg_addr_width-1:0] reg_addr_t;
  typedef logic [data_width-1:0]     data_t;

  typedef struct packed {
    logic [opcode_width-1:0] opcode;
    reg_addr_t               rs;
    reg_addr_t               rt;
    reg_addr_t               rd;
    logic [shamt_width-1:0]  shamt;
    logic [inst_width-opcode_width-3*reg_addr_width-shamt_width-1:0] unused;
  } r_inst_t;

  typedef struct packed {
    logic [opcode_width-1:0] opcode;
    reg_addr_t               rs;
    reg_addr_t               rt;
    logic [imm_width-1:0]    imm;
  } i_inst_t;

  // view picked by the opcode
  typedef union packed {
    r_inst_t r;
    i_inst_t i;
  } inst_u;

  typedef struct packed {
    logic  valid;
    inst_u inst0;
    inst_u inst1;
  } issue_pair_t;

  // lane result, both forward path and retire port
  typedef struct packed {
    logic      valid;
    reg_addr_t dest;
    data_t     data;
  } wb_t;

endpackage

/* src/exec_core.sv */
`timescale 1ns/1ps

module exec_core (
  input  logic                  clk,
  input  logic                  rst,
  input  core_pkg::issue_pair_t issue,
  output core_pkg::wb_t         retire0,
  output core_pkg::wb_t         retire1
);

  import core_pkg::*;

  reg_addr_t rs_addr0;
  reg_addr_t rt_addr0;
  reg_addr_t rs_addr1;
  reg_addr_t rt_addr1;
  data_t     rs_data0;
  data_t     rt_data0;
  data_t     rs_data1;
  data_t     rt_data1;
  wb_t       fwd0;
  wb_t       fwd1;

  ////////////////////////////////////////
  // lanes
  ////////////////////////////////////////

  alu_lane lane0_i (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue.valid),
    .inst        (issue.inst0),
    .rs_addr     (rs_addr0),
    .rt_addr     (rt_addr0),
    .rs_data     (rs_data0),
    .rt_data     (rt_data0),
    .fwd0        (fwd0),
    .fwd1        (fwd1),
    .fwd         (fwd0),
    .retire      (retire0)
  );

  alu_lane lane1_i (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue.valid),
    .inst        (issue.inst1),
    .rs_addr     (rs_addr1),
    .rt_addr     (rt_addr1),
    .rs_data     (rs_data1),
    .rt_data     (rt_data1),
    .fwd0        (fwd0),
    .fwd1        (fwd1),
    .fwd         (fwd1),
    .retire      (retire1)
  );

  // retire ports double as the write ports
  reg_file reg_file_i (
    .clk      (clk),
    .rst      (rst),
    .wr0      (retire0),
    .wr1      (retire1),
    .rd_addr0 (rs_addr0),
    .rd_addr1 (rt_addr0),
    .rd_addr2 (rs_addr1),
    .rd_addr3 (rt_addr1),
    .rd_data0 (rs_data0),
    .rd_data1 (rt_data0),
    .rd_data2 (rs_data1),
    .rd_data3 (rt_data1)
  );

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                clk,
  input  logic                rst,
  input  core_pkg::wb_t       wr0,
  input  core_pkg::wb_t       wr1,
  input  core_pkg::reg_addr_t rd_addr0,
  input  core_pkg::reg_addr_t rd_addr1,
  input  core_pkg::reg_addr_t rd_addr2,
  input  core_pkg::reg_addr_t rd_addr3,
  output core_pkg::data_t     rd_data0,
  output core_pkg::data_t     rd_data1,
  output core_pkg::data_t     rd_data2,
  output core_pkg::data_t     rd_data3
);

  import core_pkg::*;

  data_t     regs [num_regs];
  reg_addr_t addr_a [num_rd_ports];
  data_t     data_a [num_rd_ports];

  ////////////////////////////////////////
  // write ports
  ////////////////////////////////////////

  // wr1 is written last so it wins on a shared destination
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < num_regs; r++) begin
        regs[r] <= '0;
      end
    end else begin
      if (wr0.valid) begin
        regs[wr0.dest] <= wr0.data;
      end
      if (wr1.valid) begin
        regs[wr1.dest] <= wr1.data;
      end
    end
  end

  ////////////////////////////////////////
  // read ports with write bypass
  ////////////////////////////////////////

  assign addr_a[0] = rd_addr0;
  assign addr_a[1] = rd_addr1;
  assign addr_a[2] = rd_addr2;
  assign addr_a[3] = rd_addr3;

  for (genvar p = 0; p < num_rd_ports; p++) begin : g_rd
    always_comb begin
      if (addr_a[p] == '0) begin
        data_a[p] = '0;
      end else if (wr1.valid && wr1.dest == addr_a[p]) begin
        data_a[p] = wr1.data;
      end else if (wr0.valid && wr0.dest == addr_a[p]) begin
        data_a[p] = wr0.data;
      end else begin
        data_a[p] = regs[addr_a[p]];
      end
    end
  end

  assign rd_data0 = data_a[0];
  assign rd_data1 = data_a[1];
  assign rd_data2 = data_a[2];
  assign rd_data3 = data_a[3];

  // lanes drop results for r0 at decode
  assert property (@(posedge clk) disable iff (rst)
    !(wr0.valid && wr0.dest == '0) && !(wr1.valid && wr1.dest == '0))
    else $error("reg_file: valid write to register 0");

endmodule

/* verif/exec_core_model.svh */
// architectural state as the pairs define it
// r0 is never written
data_t model_regs [num_regs];

// expected result of one instruction against the current state
function automatic wb_t predict_result(inst_u inst);
  wb_t   e;
  data_t a;
  data_t b;
  data_t imm;
  logic  known;
  e      = '0;
  known  = 1'b1;
  a      = model_regs[inst.r.rs];
  b      = model_regs[inst.r.rt];
  imm    = {16'h0000, inst.i.imm};
  e.dest = inst.r.rd;
  case (inst.r.opcode)
    op_add:  e.data = a + b;
    op_sub:  e.data = a - b;
    op_and:  e.data = a & b;
    op_or:   e.data = a | b;
    op_xor:  e.data = a ^ b;
    op_slt:  e.data = {31'b0, $signed(a) < $signed(b)};
    op_sll:  e.data = b << inst.r.shamt;
    op_srl:  e.data = b >> inst.r.shamt;
    default: begin
      // immediate forms write rt
      e.dest = inst.i.rt;
      case (inst.i.opcode)
        op_addi: e.data = a + imm;
        op_andi: e.data = a & imm;
        op_ori:  e.data = a | imm;
        op_lui:  e.data = {inst.i.imm, 16'h0000};
        default: known = 1'b0;
      endcase
    end
  endcase
  e.valid = known && (e.dest != '0);
  return e;
endfunction

// both lanes see the state before the pair
// lane 1 writes last
task automatic apply_pair(input inst_u i0, input inst_u i1, output wb_t e0, output wb_t e1);
  e0 = predict_result(i0);
  e1 = predict_result(i1);
  if (e0.valid) begin
    model_regs[e0.dest] = e0.data;
  end
  if (e1.valid) begin
    model_regs[e1.dest] = e1.data;
  end
endtask

/* verif/exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb;

  import core_pkg::*;

  localparam int num_random_pairs = 300;
  localparam int drain_timeout    = 50;

  logic        clk;
  logic        rst;
  issue_pair_t issue;
  wb_t         retire0;
  wb_t         retire1;
  int          seed;
  int          errors;
  int          pairs;
  int          v;
  wb_t         issue_exp0;
  wb_t         issue_exp1;
  int          issue_id;
  // expected results staged to line up with the retire ports
  wb_t         exp0 [3];
  wb_t         exp1 [3];
  int          exp_id [3];
  string       test_names [6];
  logic [opcode_width-1:0] kept_ops [12];

  `include "exec_core_model.svh"

  exec_core exec_core_i (
    .clk     (clk),
    .rst     (rst),
    .issue   (issue),
    .retire0 (retire0),
    .retire1 (retire1)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst) begin
      exp0   <= '{default: '0};
      exp1   <= '{default: '0};
      exp_id <= '{default: 0};
    end else begin
      exp0   <= '{issue_exp0, exp0[0], exp0[1]};
      exp1   <= '{issue_exp1, exp1[0], exp1[1]};
      exp_id <= '{issue_id, exp_id[0], exp_id[1]};
    end
  end

  // dest and data only matter on a valid result
  function automatic logic wb_match(wb_t got, wb_t want);
    return got.valid == want.valid &&
           (!want.valid || (got.dest == want.dest && got.data == want.data));
  endfunction

  assert property (@(posedge clk) disable iff (rst) wb_match(retire0, exp0[2]))
    else begin
      errors++;
      $display("[FAIL] %s lane 0: expected %h actual %h",
               test_names[$sampled(exp_id[2])], $sampled(exp0[2]), $sampled(retire0));
    end

  assert property (@(posedge clk) disable iff (rst) wb_match(retire1, exp1[2]))
    else begin
      errors++;
      $display("[FAIL] %s lane 1: expected %h actual %h",
               test_names[$sampled(exp_id[2])], $sampled(exp1[2]), $sampled(retire1));
    end

  // build the word in the view its opcode selects
  // shamt comes from imm[4:0]
  function automatic inst_u encode(logic [5:0] op, reg_addr_t dest, reg_addr_t rs,
                                   reg_addr_t rt, logic [15:0] imm);
    inst_u u;
    if (op inside {op_addi, op_andi, op_ori, op_lui}) begin
      u.i = '{opcode: op, rs: rs, rt: dest, imm: imm};
    end else begin
      u.r = '{opcode: op, rs: rs, rt: rt, rd: dest, shamt: imm[4:0], unused: '0};
    end
    return u;
  endfunction

  // mostly r1 to r4 so that results feed later pairs
  function automatic reg_addr_t pick_reg();
    int r;
    r = $random(seed);
    if (r[2:0] == 3'd0) begin
      return r[7:3];
    end
    return {3'b000, r[4:3]} + 5'd1;
  endfunction

  function automatic inst_u random_inst();
    int r;
    r = $random(seed);
    return encode({2'b00, r[3:0]}, pick_reg(), pick_reg(), pick_reg(), r[31:16]);
  endfunction

  task automatic send_pair(int id, inst_u i0, inst_u i1);
    wb_t e0;
    wb_t e1;
    @(posedge clk);
    #5;
    apply_pair(i0, i1, e0, e1);
    issue      = '{valid: 1'b1, inst0: i0, inst1: i1};
    issue_exp0 = e0;
    issue_exp1 = e1;
    issue_id   = id;
    pairs++;
  endtask

  // instruction words keep changing while valid is low
  task automatic idle(int n);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      #5;
      issue.valid      = 1'b0;
      issue.inst0      = inst_u'($random(seed));
      issue.inst1      = inst_u'($random(seed));
      issue_exp0.valid = 1'b0;
      issue_exp1.valid = 1'b0;
    end
  endtask

  function automatic logic pending();
    logic p;
    p = retire0.valid || retire1.valid;
    for (int s = 0; s < 3; s++) begin
      p = p || exp0[s].valid || exp1[s].valid;
    end
    return p;
  endfunction

  task automatic report_and_finish();
    $display("pairs issued: %0d, errors: %0d", pairs, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (pending() && waited < drain_timeout) begin
      @(posedge clk);
      #5;
      waited++;
    end
    if (pending()) begin
      errors++;
      $display("retire ports still busy %0d cycles after the last pair", drain_timeout);
    end
  endtask

  initial begin
    seed       = 32'h423b5014;
    errors     = 0;
    pairs      = 0;
    rst        = 1'b1;
    issue      = '0;
    issue_exp0 = '0;
    issue_exp1 = '0;
    issue_id   = 0;
    for (int r = 0; r < num_regs; r++) begin
      model_regs[r] = '0;
    end
    test_names = '{"reset_zero", "alu_ops", "forwarding", "same_dest", "r0_and_nop", "random"};
    kept_ops   = '{op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sll, op_srl,
                   op_addi, op_andi, op_ori, op_lui};
    repeat (2) @(posedge clk);
    #5;
    rst = 1'b0;

    ////////////////////////////////////////
    // directed pairs
    ////////////////////////////////////////

    idle(2);
    send_pair(0, encode(op_add, 5'd5, 5'd6, 5'd7, 16'h0),
                 encode(op_ori, 5'd8, 5'd9, 5'd0, 16'h1234));
    send_pair(1, encode(op_lui, 5'd1, 5'd0, 5'd0, 16'h8000),
                 encode(op_addi, 5'd2, 5'd0, 5'd0, 16'h0123));
    for (int k = 0; k < 12; k++) begin
      send_pair(1, encode(kept_ops[k], 5'd10, 5'd1, 5'd2, 16'h0f04),
                   encode(kept_ops[k], 5'd11, 5'd2, 5'd1, 16'hf0a3));
    end
    // forwarding within and across lanes then through the retire bypass
    send_pair(2, encode(op_addi, 5'd3, 5'd0, 5'd0, 16'h0010),
                 encode(op_addi, 5'd4, 5'd0, 5'd0, 16'h0020));
    send_pair(2, encode(op_add, 5'd5, 5'd3, 5'd3, 16'h0), encode(op_add, 5'd6, 5'd4, 5'd3, 16'h0));
    send_pair(2, encode(op_sub, 5'd7, 5'd6, 5'd5, 16'h0), encode(op_xor, 5'd3, 5'd5, 5'd4, 16'h0));
    send_pair(2, encode(op_or, 5'd8, 5'd3, 5'd7, 16'h0), encode(op_sll, 5'd9, 5'd0, 5'd6, 16'h2));
    idle(1);
    send_pair(3, encode(op_addi, 5'd12, 5'd1, 5'd0, 16'h1),
                 encode(op_addi, 5'd12, 5'd1, 5'd0, 16'h2));
    send_pair(3, encode(op_addi, 5'd13, 5'd0, 5'd0, 16'h0055),
                 encode(op_add, 5'd14, 5'd13, 5'd12, 16'h0));
    idle(3);
    send_pair(3, encode(op_add, 5'd15, 5'd12, 5'd13, 16'h0),
                 encode(op_or, 5'd16, 5'd12, 5'd0, 16'h0));
    send_pair(4, encode(op_addi, 5'd0, 5'd1, 5'd0, 16'h7), encode(op_add, 5'd0, 5'd1, 5'd2, 16'h0));
    send_pair(4, encode(op_add, 5'd17, 5'd0, 5'd0, 16'h0),
                 encode(op_ori, 5'd18, 5'd0, 5'd0, 16'h0042));
    send_pair(4, encode(6'h3f, 5'd17, 5'd1, 5'd2, 16'h0), encode(6'h00, 5'd18, 5'd1, 5'd2, 16'h0));
    idle(2);

    ////////////////////////////////////////
    // random pairs with idle gaps
    ////////////////////////////////////////

    for (int n = 0; n < num_random_pairs; n++) begin
      v = $random(seed);
      if (v[1:0] == 2'd0) begin
        idle(int'(v[3:2]) + 1);
      end
      send_pair(5, random_inst(), random_inst());
    end
    idle(1);
    drain();
    report_and_finish();
  end

endmodule
